//--- Bender.yml
package:
  name: execCore

sources:
  - verilog/execPkg.sv
  - verilog/aluShift.sv
  - verilog/aluFast.sv
  - verilog/cmdDecoder.sv
  - verilog/regRow.sv
  - verilog/regReadMux.sv
  - verilog/flowCtrl.sv
  - verilog/execCore.sv
  - target: simulation
    files:
      - verification/execCoreChk.sv
      - verification/execCoreTb.sv

//--- src.f
verilog/execPkg.sv
verilog/aluShift.sv
verilog/aluFast.sv
verilog/cmdDecoder.sv
verilog/regRow.sv
verilog/regReadMux.sv
verilog/flowCtrl.sv
verilog/execCore.sv
verification/execCoreChk.sv
verification/execCoreTb.sv

//--- verification/execCoreChk.sv
`timescale 1ns/1ns

module execCoreChk #(
  parameter int ipWidth = 24
) (
  input logic clk,
  input logic rst,
  input logic cmdValid,
  input execPkg::cmdWord_t cmd,
  input execPkg::regIdx_t rdIdx,
  input logic [execPkg::dataWidth-1:0] rdData,
  input execPkg::flags_t flags,
  input logic [ipWidth-1:0] ip
);

  int failCount = 0;  // Assertion failures so far

  // ****************************************
  // Reset and instruction pointer
  // ****************************************

  resetClears: assert property (@(posedge clk) rst |=> (ip == '0 && flags == '0))
    else begin
      $error("ip or flags not zero after reset");
      failCount++;
    end

  idleHoldsIp: assert property (@(posedge clk) disable iff (rst)
    !cmdValid |=> ip == $past(ip))
    else begin
      $error("ip changed in an idle cycle");
      failCount++;
    end

  aluStepsIp: assert property (@(posedge clk) disable iff (rst)
    cmdValid && !cmd.alu.isJmp |=> ip == ipWidth'($past(ip) + 1))
    else begin
      $error("ip did not advance by one after an ALU command");
      failCount++;
    end

  // Cond 7 never jumps
  neverJumps: assert property (@(posedge clk) disable iff (rst)
    cmdValid && cmd.jmp.isJmp && cmd.jmp.cond == 4'h7 |=> ip == ipWidth'($past(ip) + 1))
    else begin
      $error("jump with the never condition moved ip by more than one");
      failCount++;
    end

  rowZeroReads: assert property (@(posedge clk) rdIdx.row == 3'd0 |-> rdData == '0)
    else begin
      $error("row 0 read returned a nonzero value");
      failCount++;
    end

endmodule

//--- verification/execCoreTb.sv
`timescale 1ns/1ns

module execCoreTb;

  localparam int ipWidth = 24;
  localparam int nArith = 6;
  localparam int nShift = 2;
  localparam int nBit = 2;
  // Commands of all tests, one word load is 11 commands
  localparam int numCmds = 5 + nArith * 35 + nShift * 47 + nBit * 20 + 79 + 1;

  logic clk = 1'b0;
  logic rst;
  logic cmdValid;
  execPkg::cmdWord_t cmd;
  execPkg::regIdx_t rdIdx;
  logic [execPkg::dataWidth-1:0] rdData;
  execPkg::flags_t flags;
  logic [ipWidth-1:0] ip;

  logic [63:0] mRegs [1:7];  // Reference model state
  execPkg::flags_t mFlags;
  logic [ipWidth-1:0] mIp;

  integer seed;
  int errors = 0;
  int testStartErr = 0;
  int testsOk = 0;
  int testsBad = 0;

  execCore #(.ipWidth(ipWidth)) dut_i (
    .clk(clk),
    .rst(rst),
    .cmdValid(cmdValid),
    .cmd(cmd),
    .rdIdx(rdIdx),
    .rdData(rdData),
    .flags(flags),
    .ip(ip)
  );

  bind execCore execCoreChk #(.ipWidth(ipWidth)) chk_i (
    .clk(clk),
    .rst(rst),
    .cmdValid(cmdValid),
    .cmd(cmd),
    .rdIdx(rdIdx),
    .rdData(rdData),
    .flags(flags),
    .ip(ip)
  );

  always #2 clk = ~clk;

  initial begin
    #(numCmds * 4 * 4 + 5 * 4);  // Four times the command time plus reset
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  // ****************************************
  // Command builders and model helpers
  // ****************************************

  function automatic execPkg::regIdx_t mkIdx(logic [1:0] ww, logic hi, logic [2:0] row);
    return execPkg::regIdx_t'{ww, hi, row};
  endfunction

  function automatic execPkg::cmdWord_t mkAlu(logic [1:0] unit, logic [1:0] oper, logic fw,
      execPkg::regIdx_t s, execPkg::regIdx_t u, execPkg::regIdx_t d, logic ui, logic [6:0] imm);
    execPkg::cmdWord_t w;
    w.alu = execPkg::aluCmd_t'{1'b0, unit, oper, fw, s, u, d, ui, imm};
    return w;
  endfunction

  function automatic execPkg::cmdWord_t mkJmp(logic [3:0] cond, logic [23:0] off);
    execPkg::cmdWord_t w;
    w.jmp = execPkg::jmpCmd_t'{1'b1, cond, 3'b000, off};
    return w;
  endfunction

  function automatic logic [63:0] readSec(execPkg::regIdx_t idx);
    logic [63:0] row;
    row = (idx.row == 3'd0) ? 64'h0 : mRegs[idx.row];
    case (idx.ww)
      execPkg::wwByte: return idx.hi ? 64'(row[15:8]) : 64'(row[7:0]);
      execPkg::wwHalf: return idx.hi ? 64'(row[31:16]) : 64'(row[15:0]);
      execPkg::wwWord: return idx.hi ? 64'(row[63:32]) : 64'(row[31:0]);
      default: return row;
    endcase
  endfunction

  function automatic int sizeOf(logic [1:0] ww);
    return (ww == execPkg::wwByte) ? 8 : (ww == execPkg::wwHalf) ? 16 : 32;
  endfunction

  function automatic logic [31:0] maskSz(logic [31:0] val, int sz);
    return (sz == 32) ? val : val & ((32'h1 << sz) - 32'h1);
  endfunction

  function automatic logic condHolds(logic [3:0] cond, execPkg::flags_t f);
    logic sm;
    sm = f.n ^ f.v;  // Smaller
    case (cond)
      4'h0: return 1'b1;
      4'h1: return f.z | f.c;
      4'h2: return f.c;
      4'h3: return ~f.c;
      4'h4: return f.z;
      4'h5: return ~f.z;
      4'h6: return ~f.z & ~f.c;
      4'h7: return 1'b0;
      4'h8: return ~f.z & ~sm;
      4'h9: return f.z | ~sm;
      4'hA: return sm;
      4'hB: return f.z | sm;
      4'hC: return f.n;
      4'hD: return f.v;
      4'hE: return ~f.n;
      default: return ~f.v;
    endcase
  endfunction

  task automatic writeSec(input execPkg::regIdx_t idx, input logic [31:0] res);
    if (idx.row == 3'd0) return;  // Row 0 ignores writes
    case (idx.ww)
      execPkg::wwByte: begin
        if (idx.hi) mRegs[idx.row][15:8] = res[7:0];
        else mRegs[idx.row][7:0] = res[7:0];
      end
      execPkg::wwHalf: begin
        if (idx.hi) mRegs[idx.row][31:16] = res[15:0];
        else mRegs[idx.row][15:0] = res[15:0];
      end
      execPkg::wwWord: begin
        if (idx.hi) mRegs[idx.row][63:32] = res;
        else mRegs[idx.row][31:0] = res;
      end
      default: mRegs[idx.row] = {32'h0, res};
    endcase
  endtask

  task automatic modelStep(input execPkg::cmdWord_t w);
    execPkg::aluCmd_t a;
    logic [31:0] s;
    logic [31:0] u;
    logic [31:0] r;
    logic [63:0] sx;
    logic c;
    logic v;
    logic wr;
    int sz;
    int n;
    if (w.jmp.isJmp) begin
      mIp = condHolds(w.jmp.cond, mFlags) ? mIp + ipWidth'(w.jmp.offset) : mIp + 1'b1;
      return;
    end
    a = w.alu;
    mIp = mIp + 1'b1;
    u = 32'(readSec(a.srcU));
    s = a.useImm ? {{25{a.imm[6]}}, a.imm} : 32'(readSec(a.srcS));
    sz = sizeOf(a.dst.ww);
    n = s[4:0];
    r = '0;
    c = 1'b0;
    v = 1'b0;
    wr = 1'b1;
    case (a.unit)
      execPkg::unitArith: begin
        case (a.oper)
          execPkg::opAdd: begin
            {c, r} = {1'b0, u} + {1'b0, s};
            v = (s[sz-1] == u[sz-1]) && (r[sz-1] != u[sz-1]);
          end
          execPkg::opSub: begin
            r = u - s;
            c = u < s;  // Borrow
            v = (s[sz-1] != u[sz-1]) && (r[sz-1] != u[sz-1]);
          end
          execPkg::opAnd: r = u & s;
          default: r = u ^ s;
        endcase
      end
      execPkg::unitShift: begin
        case (a.oper)
          execPkg::opShl: begin
            r = u << n;
            c = (n != 0 && n <= sz) ? u[sz-n] : 1'b0;
          end
          execPkg::opShr: begin
            r = u >> n;
            c = (n != 0) ? u[n-1] : 1'b0;
          end
          execPkg::opAsr: begin
            sx = 64'(maskSz(u, sz));
            if (u[sz-1]) sx = sx | (~64'h0 << sz);
            r = 32'(sx >> n);
            c = (n != 0) ? sx[n-1] : 1'b0;
          end
          default: begin
            n = n % sz;  // Rotate within the destination size
            r = maskSz(u, sz);
            if (n != 0) begin
              r = maskSz((r << n) | (r >> (sz - n)), sz);
              c = r[0];
            end
          end
        endcase
      end
      execPkg::unitBit: begin
        c = u[n];
        case (a.oper)
          execPkg::opBt: r = u;
          execPkg::opBts: r = u | (32'h1 << n);
          execPkg::opBtr: r = u & ~(32'h1 << n);
          default: wr = 1'b0;
        endcase
      end
      default: wr = 1'b0;
    endcase
    if (wr) begin
      writeSec(a.dst, r);
      if (a.flagWr) mFlags = execPkg::flags_t'{v, r[sz-1], maskSz(r, sz) == 32'h0, c};
    end
  endtask

  // ****************************************
  // Driving and checking
  // ****************************************

  task automatic checkState();
    assert (flags === mFlags) else begin
      $display("mismatch at %0t: flags %b, expected %b", $time, flags, mFlags);
      errors++;
    end
    assert (ip === mIp) else begin
      $display("mismatch at %0t: ip %h, expected %h", $time, ip, mIp);
      errors++;
    end
  endtask

  task automatic checkSec(input execPkg::regIdx_t idx);
    @(posedge clk);
    rdIdx <= idx;
    @(negedge clk);
    assert (rdData === readSec(idx)) else begin
      $display("mismatch at %0t: row %0d ww %0d hi %0d read %h, expected %h",
               $time, idx.row, idx.ww, idx.hi, rdData, readSec(idx));
      errors++;
    end
  endtask

  task automatic issue(input execPkg::cmdWord_t w);
    @(posedge clk);
    cmdValid <= 1'b1;
    cmd <= w;
    @(posedge clk);
    cmdValid <= 1'b0;
    modelStep(w);
    @(negedge clk);
    checkState();
    if (!w.alu.isJmp) checkSec(w.alu.dst);
  endtask

  // Builds a word in 6-bit steps so the immediate never sign-extends
  task automatic loadWord(input logic [2:0] row, input logic [31:0] val);
    execPkg::regIdx_t d;
    d = mkIdx(execPkg::wwWord, 1'b0, row);
    issue(mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b0, '0,
                mkIdx(execPkg::wwWord, 1'b0, 3'd0), d, 1'b1, {5'b0, val[31:30]}));
    for (int k = 4; k >= 0; k--) begin
      issue(mkAlu(execPkg::unitShift, execPkg::opShl, 1'b0, '0, d, d, 1'b1, 7'd6));
      issue(mkAlu(execPkg::unitArith, execPkg::opXor, 1'b0, '0, d, d, 1'b1, {1'b0, val[k*6 +: 6]}));
    end
  endtask

  task automatic endTest(input string name);
    if (errors == testStartErr) begin
      testsOk++;
      $display("test %s: ok", name);
    end else begin
      testsBad++;
      $display("test %s: %0d mismatches", name, errors - testStartErr);
    end
    testStartErr = errors;
  endtask

  initial begin
    execPkg::cmdWord_t setup;
    execPkg::regIdx_t zeroW;
    seed = 42467;
    rst = 1'b1;
    cmdValid = 1'b0;
    cmd = '0;
    rdIdx = '0;
    for (int i = 1; i <= 7; i++) mRegs[i] = 64'h0;
    mFlags = '0;
    mIp = '0;
    zeroW = mkIdx(execPkg::wwWord, 1'b0, 3'd0);
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Full row first, then one byte, byte1, half1 and upper word
    issue(mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b0, '0, zeroW,
                mkIdx(execPkg::wwDword, 1'b0, 3'd3), 1'b1, 7'h7F));
    for (int k = 0; k < 4; k++) begin
      issue(mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b0, '0, zeroW,
                  mkIdx(2'((k == 0) ? 0 : k - 1), k != 0, 3'd3), 1'b1, 7'($random(seed))));
      for (int ww = 0; ww < 4; ww++) begin  // Every section, written or not
        for (int hi = 0; hi < 2; hi++) checkSec(mkIdx(2'(ww), 1'(hi), 3'd3));
      end
    end
    endTest("sectioned writes");

    for (int it = 0; it < nArith; it++) begin
      loadWord(3'd4, $random(seed));
      loadWord(3'd5, $random(seed));
      for (int sz = 0; sz < 3; sz++) begin
        for (int op = 0; op < 4; op++) begin
          issue(mkAlu(execPkg::unitArith, 2'(op), 1'b1, mkIdx(2'(sz), 1'b0, 3'd4),
                      mkIdx(2'(sz), 1'b0, 3'd5), mkIdx(2'(sz), 1'(it), 3'd6), 1'b0, '0));
        end
      end
      issue(mkAlu(execPkg::unitArith, execPkg::opSub, 1'b0, mkIdx(execPkg::wwWord, 1'b0, 3'd5),
                  mkIdx(execPkg::wwWord, 1'b0, 3'd4), mkIdx(execPkg::wwWord, 1'b0, 3'd6), 1'b0, '0));
    end
    endTest("arithmetic and flags");

    for (int it = 0; it < nShift; it++) begin
      loadWord(3'd4, $random(seed));
      for (int sz = 0; sz < 3; sz++) begin
        for (int op = 0; op < 4; op++) begin
          for (int a = 0; a < 3; a++) begin
            issue(mkAlu(execPkg::unitShift, 2'(op), 1'b1, '0, mkIdx(2'(sz), 1'b0, 3'd4),
                        mkIdx(2'(sz), 1'b0, 3'd7), 1'b1, (a < 2) ? 7'(a) : 7'($random(seed) & 31)));
          end
        end
      end
    end
    endTest("shifts");

    for (int it = 0; it < nBit; it++) begin
      loadWord(3'd4, $random(seed));
      for (int sz = 0; sz < 3; sz++) begin
        for (int op = 0; op < 3; op++) begin
          issue(mkAlu(execPkg::unitBit, 2'(op), 1'b1, '0, mkIdx(2'(sz), 1'b0, 3'd4),
                      mkIdx(2'(sz), 1'b0, 3'd7), 1'b1,
                      7'(($random(seed) & 32'h7FFFFFFF) % sizeOf(2'(sz)))));
        end
      end
    end
    endTest("bit operations");

    loadWord(3'd2, 32'h7FFF_FFFF);
    for (int k = 0; k < 4; k++) begin
      case (k)
        0: setup = mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b1, '0,
                         mkIdx(execPkg::wwWord, 1'b0, 3'd2), mkIdx(execPkg::wwWord, 1'b0, 3'd1),
                         1'b1, 7'h01);  // Overflow into the sign
        1: setup = mkAlu(execPkg::unitArith, execPkg::opSub, 1'b1, '0, zeroW,
                         mkIdx(execPkg::wwWord, 1'b0, 3'd1), 1'b1, 7'h01);
        2: setup = mkAlu(execPkg::unitArith, execPkg::opSub, 1'b1, '0, zeroW,
                         mkIdx(execPkg::wwWord, 1'b0, 3'd1), 1'b1, 7'h00);
        default: setup = mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b1, '0,
                               mkIdx(execPkg::wwWord, 1'b0, 3'd2),
                               mkIdx(execPkg::wwWord, 1'b0, 3'd1), 1'b1, 7'h7F);
      endcase
      issue(setup);
      for (int cond = 0; cond < 16; cond++) begin
        issue(mkJmp(4'(cond), 24'($random(seed) % 512)));
      end
    end
    endTest("jumps");

    issue(mkAlu(execPkg::unitArith, execPkg::opAdd, 1'b1, '0, mkIdx(execPkg::wwWord, 1'b0, 3'd3),
                mkIdx(execPkg::wwDword, 1'b0, 3'd0), 1'b1, 7'h15));
    repeat (6) begin
      @(posedge clk);
      cmd <= execPkg::cmdWord_t'($random(seed));  // Junk while the strobe is low
    end
    @(negedge clk);
    checkState();
    for (int row = 0; row < 8; row++) checkSec(mkIdx(execPkg::wwDword, 1'b0, 3'(row)));
    endTest("row 0 and idle");

    $display("tests ok %0d, tests with mismatches %0d, assertion failures %0d",
             testsOk, testsBad, dut_i.chk_i.failCount);
    if (errors == 0 && dut_i.chk_i.failCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog/aluFast.sv
`timescale 1ns/1ns

module aluFast (
  input logic [execPkg::dataWidth-1:0] opS,
  input logic [execPkg::dataWidth-1:0] opU,
  input execPkg::aluCtrl_t aluCtrl,
  input execPkg::flags_t flagsIn,
  output execPkg::wrBus_t wrBus,
  output execPkg::flags_t flagData,
  output logic flagLoad
);

  localparam int w = execPkg::aluWidth;

  logic [w-1:0] valS;
  logic [w-1:0] valU;
  logic [w-1:0] addS;
  logic [w:0] addSum;
  logic [w-1:0] bitMask;
  logic [w-1:0] shRes;
  logic [w-1:0] result;
  logic [execPkg::dataWidth-1:0] aligned;
  logic [1:0] ww;
  logic isSub;
  logic isAddSub;
  logic shCarry;
  logic carry;
  logic doWrite;
  logic signS;
  logic signU;
  logic signR;
  logic overflow;
  execPkg::flags_t newFlags;

  function automatic logic signAt(logic [w-1:0] val, logic [1:0] size);
    case (size)
      execPkg::wwByte: return val[7];
      execPkg::wwHalf: return val[15];
      default: return val[w-1];
    endcase
  endfunction

  assign valS = aluCtrl.useImm ? aluCtrl.imm : opS[w-1:0];
  assign valU = opU[w-1:0];
  assign ww = execPkg::colToWw(aluCtrl.dst.col);

  // ****************************************
  // Adder, U - S done as U + ~S + 1
  // ****************************************
  assign isSub = (aluCtrl.oper == execPkg::opSub);
  assign isAddSub = (aluCtrl.unit == execPkg::unitArith) &
                    ((aluCtrl.oper == execPkg::opAdd) | isSub);
  assign addS = isSub ? ~valS : valS;
  assign addSum = {1'b0, valU} + {1'b0, addS} + {{w{1'b0}}, isSub};

  assign bitMask = w'(1) << valS[4:0];

  aluShift shift_i (
    .data(valU),
    .amount(valS[4:0]),
    .oper(aluCtrl.oper),
    .col(aluCtrl.dst.col),
    .result(shRes),
    .carry(shCarry)
  );

  always_comb begin
    result = '0;
    carry = 1'b0;
    doWrite = 1'b1;
    case (aluCtrl.unit)
      execPkg::unitArith: begin
        case (aluCtrl.oper)
          execPkg::opAnd: result = valS & valU;
          execPkg::opXor: result = valS ^ valU;
          default: begin
            result = addSum[w-1:0];
            carry = addSum[w] ^ isSub;  // Borrow on sub
          end
        endcase
      end
      execPkg::unitShift: begin
        result = shRes;
        carry = shCarry;
      end
      execPkg::unitBit: begin
        carry = |(valU & bitMask);  // Bit before the change
        case (aluCtrl.oper)
          execPkg::opBt: result = valU;
          execPkg::opBts: result = valU | bitMask;
          execPkg::opBtr: result = valU & ~bitMask;
          default: doWrite = 1'b0;
        endcase
      end
      default: doWrite = 1'b0;
    endcase
  end

  // Place the result into its section
  always_comb begin
    case (aluCtrl.dst.col)
      execPkg::colFull: aligned = {32'h0, result};
      execPkg::colWord1: aligned = {result, 32'h0};
      execPkg::colWord0: aligned = {32'h0, result};
      execPkg::colHalf1: aligned = {32'h0, result[15:0], 16'h0};
      execPkg::colHalf0: aligned = {48'h0, result[15:0]};
      execPkg::colByte1: aligned = {48'h0, result[7:0], 8'h0};
      execPkg::colByte0: aligned = {56'h0, result[7:0]};
      default: aligned = '0;
    endcase
  end

  // ****************************************
  // Flags
  // ****************************************
  assign signS = signAt(addS, ww);
  assign signU = signAt(valU, ww);
  assign signR = signAt(result, ww);
  assign overflow = isAddSub & ~(signS ^ signU) & (signU ^ signR);
  assign newFlags = {overflow, signR, ~|aligned, carry};

  assign flagLoad = doWrite & aluCtrl.flagWr;
  assign flagData = flagLoad ? newFlags : flagsIn;  // Holds current flags otherwise

  assign wrBus.data = aligned;
  assign wrBus.dst = doWrite ? aluCtrl.dst : '0;
  assign wrBus.zeroRow = doWrite & aluCtrl.dst.row[0];

endmodule

//--- verilog/aluShift.sv
`timescale 1ns/1ns

module aluShift (
  input logic [execPkg::aluWidth-1:0] data,
  input logic [4:0] amount,
  input logic [1:0] oper,
  input logic [3:0] col,
  output logic [execPkg::aluWidth-1:0] result,
  output logic carry
);

  localparam int w = execPkg::aluWidth;

  logic [1:0] ww;
  logic [4:0] rolAmt;
  logic [4:0] effAmt;
  logic [4:0] sh;
  logic [w-1:0] alignL;
  logic [2*w-1:0] sext;
  logic [2*w-1:0] stg;
  logic [2*w-1:0] st1;
  logic [2*w-1:0] st2;
  logic [2*w-1:0] st3;
  logic [2*w-1:0] st4;
  logic [2*w-1:0] sl;
  logic shlOut;

  assign ww = execPkg::colToWw(col);

  // Size dependent staging inputs
  always_comb begin
    case (ww)
      execPkg::wwByte: begin
        sext = {{(2*w-8){data[7]}}, data[7:0]};
        alignL = {data[7:0], {(w-8){1'b0}}};
        rolAmt = {2'b00, amount[2:0]};
      end
      execPkg::wwHalf: begin
        sext = {{(2*w-16){data[15]}}, data[15:0]};
        alignL = {data[15:0], {(w-16){1'b0}}};
        rolAmt = {1'b0, amount[3:0]};
      end
      default: begin
        sext = {{w{data[w-1]}}, data};
        alignL = data;
        rolAmt = amount;
      end
    endcase
  end

  assign effAmt = (oper == execPkg::opRol) ? rolAmt : amount;

  // Right shifts run as a left shift by 32 - n, result taken from the top half
  always_comb begin
    case (oper)
      execPkg::opShl: begin
        stg = {{w{1'b0}}, data};
        sh = effAmt;
      end
      execPkg::opShr: begin
        stg = {{w{1'b0}}, data};
        sh = 5'd0 - effAmt;
      end
      execPkg::opAsr: begin
        stg = sext;
        sh = 5'd0 - effAmt;
      end
      default: begin
        stg = {data, alignL};  // Low bits feed the rotate
        sh = effAmt;
      end
    endcase
  end

  // ****************************************
  // Five-stage barrel shifter
  // ****************************************
  assign st1 = sh[4] ? {stg[2*w-17:0], 16'h0} : stg;
  assign st2 = sh[3] ? {st1[2*w-9:0], 8'h0} : st1;
  assign st3 = sh[2] ? {st2[2*w-5:0], 4'h0} : st2;
  assign st4 = sh[1] ? {st3[2*w-3:0], 2'h0} : st3;
  assign sl = sh[0] ? {st4[2*w-2:0], 1'b0} : st4;

  // First bit above the destination size
  assign shlOut = (ww == execPkg::wwByte) ? sl[8] :
                  (ww == execPkg::wwHalf) ? sl[16] : sl[w];

  always_comb begin
    if (effAmt == 5'd0) begin
      result = data;
      carry = 1'b0;
    end else begin
      case (oper)
        execPkg::opShl: begin
          result = sl[w-1:0];
          carry = shlOut;
        end
        execPkg::opRol: begin
          result = sl[2*w-1:w];
          carry = sl[w];  // New LSB
        end
        default: begin
          result = sl[2*w-1:w];
          carry = sl[w-1];  // Last bit out on the right
        end
      endcase
    end
  end

endmodule

//--- verilog/cmdDecoder.sv
`timescale 1ns/1ns

module cmdDecoder (
  input logic cmdValid,
  input execPkg::cmdWord_t cmd,
  output execPkg::colRow_t srcS,
  output execPkg::colRow_t srcU,
  output execPkg::aluCtrl_t aluCtrl,
  output logic isJmp,
  output logic [3:0] jmpCond,
  output logic signed [execPkg::offWidth-1:0] jmpOffset
);

  localparam int immFill = execPkg::aluWidth - 7;

  logic aluValid;
  logic jmpValid;

  // Shared MSB picks the view
  assign jmpValid = cmdValid & cmd.jmp.isJmp;
  assign aluValid = cmdValid & ~cmd.alu.isJmp;

  // ****************************************
  // ALU view
  // ****************************************

  always_comb begin
    srcS = '0;
    srcU = '0;
    aluCtrl = '0;  // Zero dst means no row is written
    if (aluValid) begin
      aluCtrl.unit = cmd.alu.unit;
      aluCtrl.oper = cmd.alu.oper;
      aluCtrl.flagWr = cmd.alu.flagWr;
      aluCtrl.useImm = cmd.alu.useImm;
      aluCtrl.imm = {{immFill{cmd.alu.imm[6]}}, cmd.alu.imm};
      aluCtrl.dst = execPkg::toColRow(cmd.alu.dst);
      srcU = execPkg::toColRow(cmd.alu.srcU);
      // S is not read at all when the immediate replaces it
      if (!cmd.alu.useImm) begin
        srcS = execPkg::toColRow(cmd.alu.srcS);
      end
    end
  end

  // ****************************************
  // Jump view
  // ****************************************

  assign isJmp = jmpValid;
  assign jmpCond = jmpValid ? cmd.jmp.cond : 4'h0;
  assign jmpOffset = jmpValid ? cmd.jmp.offset : '0;

endmodule

//--- verilog/execCore.sv
`timescale 1ns/1ns

module execCore #(
  parameter int ipWidth = execPkg::ipWidth
) (
  input logic clk,
  input logic rst,
  input logic cmdValid,
  input execPkg::cmdWord_t cmd,
  input execPkg::regIdx_t rdIdx,
  output logic [execPkg::dataWidth-1:0] rdData,
  output execPkg::flags_t flags,
  output logic [ipWidth-1:0] ip
);

  execPkg::colRow_t srcS;
  execPkg::colRow_t srcU;
  execPkg::colRow_t rdSel;
  execPkg::aluCtrl_t aluCtrl;
  logic isJmp;
  logic [3:0] jmpCond;
  logic signed [execPkg::offWidth-1:0] jmpOffset;
  logic [execPkg::dataWidth-1:0] opS;
  logic [execPkg::dataWidth-1:0] opU;
  execPkg::wrBus_t wrBus;
  execPkg::flags_t flagData;
  logic flagLoad;
  logic [execPkg::rowCount-1:0][execPkg::dataWidth-1:0] regFile;  // Entry 0 is row 1

  assign rdSel = execPkg::toColRow(rdIdx);

  cmdDecoder decoder_i (
    .cmdValid(cmdValid),
    .cmd(cmd),
    .srcS(srcS),
    .srcU(srcU),
    .aluCtrl(aluCtrl),
    .isJmp(isJmp),
    .jmpCond(jmpCond),
    .jmpOffset(jmpOffset)
  );

  // ****************************************
  // Register file
  // ****************************************

  for (genvar r = 1; r <= execPkg::rowCount; r++) begin : genRow
    regRow #(.rowNum(r)) row_i (
      .clk(clk),
      .rst(rst),
      .wrBus(wrBus),
      .rowData(regFile[r-1])
    );
  end

  regReadMux readS_i (.regFile(regFile), .sel(srcS), .data(opS));
  regReadMux readU_i (.regFile(regFile), .sel(srcU), .data(opU));
  regReadMux readExt_i (.regFile(regFile), .sel(rdSel), .data(rdData));  // Outside port

  aluFast aluFast_i (
    .opS(opS),
    .opU(opU),
    .aluCtrl(aluCtrl),
    .flagsIn(flags),
    .wrBus(wrBus),
    .flagData(flagData),
    .flagLoad(flagLoad)
  );

  flowCtrl #(.ipWidth(ipWidth)) flow_i (
    .clk(clk),
    .rst(rst),
    .cmdValid(cmdValid),
    .isJmp(isJmp),
    .jmpCond(jmpCond),
    .jmpOffset(jmpOffset),
    .flagData(flagData),
    .flagLoad(flagLoad),
    .flags(flags),
    .ip(ip)
  );

endmodule

//--- verilog/execPkg.sv
package execPkg;

  localparam int dataWidth = 64;
  localparam int aluWidth = 32;
  localparam int offWidth = 24;
  localparam int ipWidth = 24;  // Default, the top level may override
  localparam int rowCount = 7;  // Rows 1..7, row 0 is the constant zero

  // Register index size field
  localparam logic [1:0] wwByte = 2'd0;
  localparam logic [1:0] wwHalf = 2'd1;
  localparam logic [1:0] wwWord = 2'd2;
  localparam logic [1:0] wwDword = 2'd3;

  // Section codes of a row
  localparam logic [3:0] colByte0 = 4'h1;  // 7:0
  localparam logic [3:0] colByte1 = 4'h2;  // 15:8
  localparam logic [3:0] colHalf0 = 4'h3;  // 15:0
  localparam logic [3:0] colHalf1 = 4'h4;  // 31:16
  localparam logic [3:0] colWord0 = 4'h7;  // 31:0
  localparam logic [3:0] colWord1 = 4'h8;  // 63:32
  localparam logic [3:0] colFull = 4'hF;

  // ALU units
  localparam logic [1:0] unitArith = 2'd0;
  localparam logic [1:0] unitShift = 2'd1;
  localparam logic [1:0] unitBit = 2'd2;
  localparam logic [1:0] unitNop = 2'd3;

  // Operations per unit
  localparam logic [1:0] opAdd = 2'd0;
  localparam logic [1:0] opSub = 2'd1;
  localparam logic [1:0] opAnd = 2'd2;
  localparam logic [1:0] opXor = 2'd3;
  localparam logic [1:0] opShl = 2'd0;
  localparam logic [1:0] opShr = 2'd1;
  localparam logic [1:0] opAsr = 2'd2;
  localparam logic [1:0] opRol = 2'd3;
  localparam logic [1:0] opBt = 2'd0;
  localparam logic [1:0] opBts = 2'd1;
  localparam logic [1:0] opBtr = 2'd2;
  localparam logic [1:0] opBitNone = 2'd3;

  typedef struct packed {
    logic [1:0] ww;
    logic hi;     // Upper part of the size
    logic [2:0] row;
  } regIdx_t;

  typedef struct packed {
    logic [3:0] col;
    logic [rowCount:0] row;  // One-hot, bit 0 is the zero row
  } colRow_t;

  typedef struct packed {
    logic isJmp;
    logic [1:0] unit;
    logic [1:0] oper;
    logic flagWr;
    regIdx_t srcS;
    regIdx_t srcU;
    regIdx_t dst;
    logic useImm;
    logic [6:0] imm;
  } aluCmd_t;

  typedef struct packed {
    logic isJmp;
    logic [3:0] cond;
    logic [2:0] pad;
    logic signed [offWidth-1:0] offset;
  } jmpCmd_t;

  // Same word, two views; isJmp sits in the MSB of both
  typedef union packed {
    aluCmd_t alu;
    jmpCmd_t jmp;
  } cmdWord_t;

  typedef struct packed {
    logic [1:0] unit;
    logic [1:0] oper;
    logic flagWr;
    logic useImm;
    logic [aluWidth-1:0] imm;  // Already sign-extended
    colRow_t dst;
  } aluCtrl_t;

  typedef struct packed {
    logic [dataWidth-1:0] data;  // Aligned to the destination section
    colRow_t dst;
    logic zeroRow;
  } wrBus_t;

  typedef struct packed {
    logic v;
    logic n;
    logic z;
    logic c;
  } flags_t;

  // ****************************************
  // Index decoding shared by the core
  // ****************************************

  function automatic colRow_t toColRow(regIdx_t idx);
    colRow_t cr;
    case (idx.ww)
      wwByte: cr.col = idx.hi ? colByte1 : colByte0;
      wwHalf: cr.col = idx.hi ? colHalf1 : colHalf0;
      wwWord: cr.col = idx.hi ? colWord1 : colWord0;
      default: cr.col = colFull;
    endcase
    cr.row = (rowCount + 1)'(1) << idx.row;
    return cr;
  endfunction

  function automatic logic [1:0] colToWw(logic [3:0] col);
    case (col)
      colByte0, colByte1: return wwByte;
      colHalf0, colHalf1: return wwHalf;
      colWord0, colWord1: return wwWord;
      default: return wwDword;  // Full row computes as a word
    endcase
  endfunction

endpackage

//--- verilog/flowCtrl.sv
`timescale 1ns/1ns

module flowCtrl #(
  parameter int ipWidth = 24
) (
  input logic clk,
  input logic rst,
  input logic cmdValid,
  input logic isJmp,
  input logic [3:0] jmpCond,
  input logic signed [execPkg::offWidth-1:0] jmpOffset,
  input execPkg::flags_t flagData,
  input logic flagLoad,
  output execPkg::flags_t flags,
  output logic [ipWidth-1:0] ip
);

  logic smaller;
  logic condMet;
  logic jmpTaken;
  logic [ipWidth-1:0] ipStep;

  assign smaller = flags.n ^ flags.v;

  // ****************************************
  // Condition analyzer
  // ****************************************
  always_comb begin
    case (jmpCond)
      4'h0: condMet = 1'b1;
      4'h1: condMet = flags.z | flags.c;    // jbe
      4'h2: condMet = flags.c;
      4'h3: condMet = ~flags.c;
      4'h4: condMet = flags.z;
      4'h5: condMet = ~flags.z;
      4'h6: condMet = ~flags.z & ~flags.c;  // ja
      4'h7: condMet = 1'b0;
      4'h8: condMet = ~flags.z & ~smaller;  // jg
      4'h9: condMet = flags.z | ~smaller;
      4'hA: condMet = smaller;
      4'hB: condMet = flags.z | smaller;    // jse
      4'hC: condMet = flags.n;
      4'hD: condMet = flags.v;
      4'hE: condMet = ~flags.n;
      default: condMet = ~flags.v;
    endcase
  end

  assign jmpTaken = isJmp & condMet;
  assign ipStep = jmpTaken ? ipWidth'(jmpOffset) : ipWidth'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
      ip <= '0;
    end else begin
      if (flagLoad) begin
        flags <= flagData;
      end
      if (cmdValid) begin
        ip <= ip + ipStep;  // Every accepted command moves ip
      end
    end
  end

endmodule

//--- verilog/regReadMux.sv
`timescale 1ns/1ns

module regReadMux (
  input logic [execPkg::rowCount-1:0][execPkg::dataWidth-1:0] regFile,
  input execPkg::colRow_t sel,
  output logic [execPkg::dataWidth-1:0] data
);

  logic [execPkg::dataWidth-1:0] rowSel;

  // One-hot OR mux over rows 1..7
  always_comb begin
    rowSel = '0;
    for (int i = 0; i < execPkg::rowCount; i++) begin
      if (sel.row[i+1]) begin
        rowSel = rowSel | regFile[i];
      end
    end
    if (sel.row[0]) begin
      rowSel = '0;  // Row 0 reads as zero
    end
  end

  // Section down to bit 0, zero above its width
  always_comb begin
    case (sel.col)
      execPkg::colFull: data = rowSel;
      execPkg::colWord1: data = {32'h0, rowSel[63:32]};
      execPkg::colWord0: data = {32'h0, rowSel[31:0]};
      execPkg::colHalf1: data = {48'h0, rowSel[31:16]};
      execPkg::colHalf0: data = {48'h0, rowSel[15:0]};
      execPkg::colByte1: data = {56'h0, rowSel[15:8]};
      execPkg::colByte0: data = {56'h0, rowSel[7:0]};
      default: data = '0;
    endcase
  end

endmodule

//--- verilog/regRow.sv
`timescale 1ns/1ns

module regRow #(
  parameter int rowNum = 1
) (
  input logic clk,
  input logic rst,
  input execPkg::wrBus_t wrBus,
  output logic [execPkg::dataWidth-1:0] rowData
);

  logic rowHit;
  logic [3:0] secEn;  // 63:32, 31:16, 15:8, 7:0

  assign rowHit = wrBus.dst.row[rowNum] & ~wrBus.zeroRow;

  always_comb begin
    case (wrBus.dst.col)
      execPkg::colByte0: secEn = 4'b0001;
      execPkg::colByte1: secEn = 4'b0010;
      execPkg::colHalf0: secEn = 4'b0011;
      execPkg::colHalf1: secEn = 4'b0100;
      execPkg::colWord0: secEn = 4'b0111;
      execPkg::colWord1: secEn = 4'b1000;
      execPkg::colFull: secEn = 4'b1111;
      default: secEn = 4'b0000;
    endcase
    if (!rowHit) begin
      secEn = 4'b0000;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rowData <= '0;
    end else begin
      if (secEn[3]) rowData[63:32] <= wrBus.data[63:32];
      if (secEn[2]) rowData[31:16] <= wrBus.data[31:16];
      if (secEn[1]) rowData[15:8] <= wrBus.data[15:8];
      if (secEn[0]) rowData[7:0] <= wrBus.data[7:0];
    end
  end

endmodule
